// ==== all.f ====
+incdir+src
+incdir+bench
src/rvPkg.sv
src/decodeBus.sv
src/execBus.sv
src/instDecoder.sv
src/aluExecute.sv
src/resultUnit.sv
src/rvExecTop.sv
bench/tbRvExec.sv

// ==== bench/rvRefModel.svh ====
`ifndef RVREFMODEL_SVH
`define RVREFMODEL_SVH

function automatic rvPkg::xlenT refAlu(input logic [2:0] f3, input logic alt,
                                       input rvPkg::xlenT a, input rvPkg::xlenT b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[5:0];
        3'b010:  return rvPkg::xlenT'($signed(a) < $signed(b));
        3'b011:  return rvPkg::xlenT'(a < b);
        3'b100:  return a ^ b;
        3'b101:  return alt ? rvPkg::xlenT'($signed(a) >>> b[5:0]) : a >> b[5:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic rvPkg::xlenT refWord(input logic [2:0] f3, input logic alt,
                                        input rvPkg::xlenT a, input rvPkg::xlenT b);
    logic [31:0] r;
    case (f3)
        3'b000:  r = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        3'b001:  r = a[31:0] << b[4:0];
        3'b101:  r = alt ? 32'($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
        default: r = 32'h0;
    endcase
    return {{32{r[31]}}, r};
endfunction

function automatic logic refTaken(input logic [2:0] f3, input rvPkg::xlenT a,
                                  input rvPkg::xlenT b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
    endcase
endfunction

// access size in bytes: byte, half, word, double
function automatic logic [3:0] refBytes(input logic [1:0] size);
    case (size)
        2'd0:    return 4'd1;
        2'd1:    return 4'd2;
        2'd2:    return 4'd4;
        default: return 4'd8;
    endcase
endfunction

// fills the exp* variables of the bench for one instruction
task automatic computeExpected(input rvPkg::instT i, input rvPkg::xlenT p,
                               input rvPkg::xlenT a, input rvPkg::xlenT b);
    logic [2:0] f3;
    rvPkg::xlenT immI, immS, immB, immU, immJ;
    f3 = i[14:12];
    immI = {{52{i[31]}}, i[31:20]};
    immS = {{52{i[31]}}, i[31:25], i[11:7]};
    immB = {{51{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
    immU = {{32{i[31]}}, i[31:12], 12'h0};
    immJ = {{43{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
    expRd = '0;
    expWr = 1'b1;
    expRdAddr = i[11:7];
    expPc = p + 64'd4;
    expAddr = '0;
    expRead = 1'b0;
    expBytes = 4'h0;
    expSext = 1'b0;
    expMask = '0;
    expStore = b;
    expIll = 1'b0;
    expHalt = 1'b0;
    case (i[6:0])
        `RV_OP_OP: begin
            if (i[31:25] == 7'h00 || i[31:25] == 7'h20)
                expRd = refAlu(f3, i[30], a, b);
            else
                expIll = 1'b1; // M extension
        end
        `RV_OP_IMM:   expRd = refAlu(f3, f3 == 3'b101 && i[30], a, immI);
        `RV_OP_32:    expRd = refWord(f3, i[30], a, b);
        `RV_OP_IMM32: expRd = refWord(f3, f3 == 3'b101 && i[30], a, immI);
        `RV_OP_LUI:   expRd = immU;
        `RV_OP_AUIPC: expRd = p + immU;
        `RV_OP_JAL: begin
            expRd = p + 64'd4;
            expPc = p + immJ;
        end
        `RV_OP_JALR: begin
            expRd = p + 64'd4;
            expPc = (a + immI) & ~64'h1;
        end
        `RV_OP_BRANCH: begin
            expWr = 1'b0;
            if (refTaken(f3, a, b))
                expPc = p + immB;
        end
        `RV_OP_LOAD: begin
            expRead = 1'b1;
            expAddr = a + immI;
            expBytes = refBytes(f3[1:0]);
            expSext = (f3 inside {3'd0, 3'd1, 3'd2, 3'd3}); // lb lh lw ld
        end
        `RV_OP_STORE: begin
            expWr = 1'b0;
            expAddr = a + immS;
            expBytes = refBytes(f3[1:0]);
            expMask = 8'hff >> (8 - expBytes);
        end
        `RV_OP_SYSTEM: begin
            expWr = 1'b0;
            expHalt = (i == 32'h0010_0073);
            expIll = !expHalt;
        end
        default: expIll = 1'b1;
    endcase
    if (expIll)
        expWr = 1'b0;
endtask

`endif

// ==== bench/tbRvExec.sv ====
`timescale 1ns/1ns
`include "rvDefs_defs.svh"

module tbRvExec;
    logic clk, rstN, req, ack;
    rvPkg::instT inst;
    rvPkg::xlenT pc, rs1Val, rs2Val, rdData, nextPc, memAddr, storeData;
    rvPkg::regIdxT rdAddr;
    rvPkg::byteMaskT memMask;
    logic writeRd, memRead, memSext, illegal, halt;
    logic [3:0] memBytes;

    rvPkg::xlenT expRd, expPc, expAddr, expStore;
    rvPkg::regIdxT expRdAddr;
    rvPkg::byteMaskT expMask;
    logic [3:0] expBytes;
    logic expWr, expRead, expSext, expIll, expHalt;
    int errCount = 0;
    int sent = 0;
    int testErrStart = 0;

    `include "rvRefModel.svh"

    rvExecTop DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic void valueError(input string name, input rvPkg::xlenT got,
                                       input rvPkg::xlenT want);
        $display("error %s got %h expected %h", name, got, want);
        errCount++;
    endfunction

    function automatic void plainError(input string what);
        $display("%s", what);
        errCount++;
    endfunction

    // checks at the cycle ack is first seen high
    chkWr: assert property (@(posedge clk) $rose(ack) |-> writeRd == expWr)
        else valueError("writeRd", 64'(writeRd), 64'(expWr));
    chkRd: assert property (@(posedge clk)
        $rose(ack) |-> !expWr || expRead || rdData == expRd)
        else valueError("rdData", rdData, expRd);
    chkRdAddr: assert property (@(posedge clk) $rose(ack) |-> !expWr || rdAddr == expRdAddr)
        else valueError("rdAddr", 64'(rdAddr), 64'(expRdAddr));
    chkPc: assert property (@(posedge clk) $rose(ack) |-> nextPc == expPc)
        else valueError("nextPc", nextPc, expPc);
    chkRead: assert property (@(posedge clk) $rose(ack) |-> memRead == expRead)
        else valueError("memRead", 64'(memRead), 64'(expRead));
    chkMask: assert property (@(posedge clk) $rose(ack) |-> memMask == expMask)
        else valueError("memMask", 64'(memMask), 64'(expMask));
    chkAddr: assert property (@(posedge clk)
        $rose(ack) |-> !(expRead || expMask != 0) || memAddr == expAddr)
        else valueError("memAddr", memAddr, expAddr);
    chkBytes: assert property (@(posedge clk)
        $rose(ack) |-> !(expRead || expMask != 0) || memBytes == expBytes)
        else valueError("memBytes", 64'(memBytes), 64'(expBytes));
    chkSext: assert property (@(posedge clk) $rose(ack) |-> !expRead || memSext == expSext)
        else valueError("memSext", 64'(memSext), 64'(expSext));
    chkStore: assert property (@(posedge clk) $rose(ack) |-> expMask == 0 || storeData == expStore)
        else valueError("storeData", storeData, expStore);
    chkIll: assert property (@(posedge clk) $rose(ack) |-> illegal == expIll)
        else valueError("illegal", 64'(illegal), 64'(expIll));
    chkHalt: assert property (@(posedge clk) $rose(ack) |-> halt == expHalt)
        else valueError("halt", 64'(halt), 64'(expHalt));

    // handshake timing
    chkLatency: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(req, 4) && !$past(req, 5))
        else plainError("ack did not rise four edges after the capture edge");
    chkHold: assert property (@(posedge clk) disable iff (!rstN)
        ack && req |=> ack && $stable(rdData) && $stable(nextPc) && $stable(memAddr)
            && $stable(writeRd) && $stable(memMask) && $stable(memRead) && $stable(illegal)
            && $stable(storeData) && $stable(rdAddr) && $stable(memBytes)
            && $stable(memSext) && $stable(halt))
        else plainError("ack or outputs changed while req was held high");
    chkFall: assert property (@(posedge clk) disable iff (!rstN) ack && !req |=> !ack)
        else plainError("ack did not fall after req was sampled low");

    task automatic failOnTimeout(input string what);
        $display("timeout: %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // called 2 ns after a rising edge
    task automatic send(input rvPkg::instT i, input rvPkg::xlenT p, input rvPkg::xlenT a,
                        input rvPkg::xlenT b, input int extra);
        int t;
        computeExpected(i, p, a, b);
        inst = i;
        pc = p;
        rs1Val = a;
        rs2Val = b;
        req = 1'b1;
        t = 0;
        while (!ack && t < 20) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (!ack)
            failOnTimeout("no ack for a request");
        repeat (extra) begin
            @(posedge clk);
            #2;
        end
        req = 1'b0;
        t = 0;
        while (ack && t < 20) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (ack)
            failOnTimeout("ack stayed high after req fell");
        sent++;
    endtask

    task automatic endTest(input string name);
        $display("test %s: %0d errors", name, errCount - testErrStart);
        testErrStart = errCount;
    endtask

    function automatic rvPkg::xlenT randWord();
        return {$urandom, $urandom};
    endfunction

    function automatic rvPkg::instT encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [6:0] op);
        return {f7, 5'd2, 5'd1, f3, 5'd7, op};
    endfunction

    function automatic rvPkg::instT encI(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [6:0] op);
        return {imm, 5'd1, f3, 5'd9, op};
    endfunction

    function automatic rvPkg::instT encS(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic rvPkg::instT encB(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic rvPkg::instT encJ(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `RV_OP_JAL};
    endfunction

    initial begin
        logic [2:0] f3;
        logic [11:0] imm;
        logic alt;
        rvPkg::xlenT a;
        logic [2:0] brF3 [6];
        logic [2:0] wF3 [3];
        brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        wF3 = '{3'd0, 3'd1, 3'd5};
        void'($urandom(32'h81af_a29c));
        rstN = 1'b0;
        req = 1'b0;
        inst = '0;
        pc = '0;
        rs1Val = '0;
        rs2Val = '0;
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;

        assert (!ack && !writeRd && !memRead && !illegal && !halt && memMask == 0)
            else plainError("outputs not low after reset");
        for (int k = 0; k < 6; k++)
            send(encI(12'($urandom), 3'd0, `RV_OP_IMM), randWord(), randWord(), 0,
                 1 + $urandom % 5); // held req
        endTest("handshake");

        for (int k = 0; k < 24; k++) begin
            f3 = 3'($urandom);
            alt = (f3 == 3'd0 || f3 == 3'd5) && $urandom % 2;
            send(encR(alt ? 7'h20 : 7'h00, f3, `RV_OP_OP), randWord(), randWord(),
                 randWord(), 0);
            imm = 12'($urandom);
            if (f3 == 3'd1 || f3 == 3'd5)
                imm[11:6] = {1'b0, f3 == 3'd5 && alt, 4'h0};
            send(encI(imm, f3, `RV_OP_IMM), randWord(), randWord(), 0, 0);
        end
        send({20'($urandom), 5'd3, `RV_OP_LUI}, randWord(), 0, 0, 0);
        send({20'($urandom), 5'd3, `RV_OP_AUIPC}, randWord() & ~64'h3, 0, 0, 0);
        endTest("alu");

        for (int k = 0; k < 18; k++) begin
            f3 = wF3[k % 3];
            alt = (f3 != 3'd1) && $urandom % 2;
            send(encR(alt ? 7'h20 : 7'h00, f3, `RV_OP_32), 0, randWord(), randWord(), 0);
            imm = (f3 == 3'd0) ? 12'($urandom)
                : {1'b0, alt && f3 == 3'd5, 5'h0, 5'($urandom)}; // sraiw funct7 0x20
            send(encI(imm, f3, `RV_OP_IMM32), 0, randWord(), 0, 0);
        end
        endTest("word");

        for (int k = 0; k < 7; k++)
            send(encI(12'($urandom), 3'(k), `RV_OP_LOAD), 0, randWord(), 0, 0);
        for (int k = 0; k < 4; k++)
            send(encS(12'($urandom), 3'(k)), 0, randWord(), randWord(), 0);
        endTest("memory");

        for (int k = 0; k < 6; k++) begin
            a = randWord() >> 2;
            send(encB(13'($urandom) & ~13'h1, brF3[k]), randWord() & ~64'h3, a, a, 0);
            send(encB(13'($urandom) & ~13'h1, brF3[k]), randWord() & ~64'h3, a, a + 5, 0);
            send(encB(13'($urandom) & ~13'h1, brF3[k]), randWord() & ~64'h3, '1, 64'd1, 0);
        end
        send(encJ(21'($urandom) & ~21'h1), randWord() & ~64'h3, 0, 0, 0);
        send(encI(12'($urandom), 3'd0, `RV_OP_JALR), randWord() & ~64'h3, randWord(), 0, 0);
        endTest("control flow");

        send(encR(7'h01, 3'd0, `RV_OP_OP), 0, randWord(), randWord(), 0); // mul
        send(32'hffff_ffff, 0, 0, 0, 0);
        send(32'h0000_0073, 0, 0, 0, 0); // ecall
        send(32'h0010_0073, 0, 0, 0, 0); // ebreak
        endTest("illegal and halt");

        $display("tests 6, instructions %0d, errors %0d", sent, errCount);
        if (errCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end
endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tbRvExec -o simv
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

// ==== src/aluExecute.sv ====
`timescale 1ns/1ns

module aluExecute (
    input logic clk,
    input logic rstN,
    decodeBus.consumer busIn,
    execBus.producer busOut
);
    rvPkg::xlenT result;
    logic [5:0] shamt;

    assign shamt = busIn.opB[5:0];

    always_comb begin
        case (busIn.aluOp)
            rvPkg::ADD:   result = busIn.opA + busIn.opB;
            rvPkg::SUB:   result = busIn.opA - busIn.opB;
            rvPkg::XOR:   result = busIn.opA ^ busIn.opB;
            rvPkg::OR:    result = busIn.opA | busIn.opB;
            rvPkg::AND:   result = busIn.opA & busIn.opB;
            rvPkg::SLL:   result = busIn.opA << shamt;
            rvPkg::SRL:   result = busIn.opA >> shamt;
            rvPkg::SRA:   result = $signed(busIn.opA) >>> shamt;
            rvPkg::SLT:   result = rvPkg::xlenT'($signed(busIn.opA) < $signed(busIn.opB));
            rvPkg::SLTU:  result = rvPkg::xlenT'(busIn.opA < busIn.opB);
            rvPkg::PASSB: result = busIn.opB;
            default:      result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busOut.valid <= 1'b0;
            busOut.writeRd <= 1'b0;
            busOut.memRead <= 1'b0;
            busOut.memMask <= '0;
            busOut.illegal <= 1'b0;
            busOut.halt <= 1'b0;
        end else begin
            busOut.valid <= busIn.valid;
            if (busIn.valid) begin
                busOut.writeRd <= busIn.writeRd;
                busOut.memRead <= busIn.memRead;
                busOut.memMask <= busIn.memMask;
                busOut.illegal <= busIn.illegal;
                busOut.halt <= busIn.halt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busIn.valid) begin
            busOut.aluResult <= result;
            busOut.wbSel <= busIn.wbSel;
            busOut.flow <= busIn.flow;
            busOut.brCond <= busIn.brCond;
            busOut.rdAddr <= busIn.rdAddr;
            busOut.memBytes <= busIn.memBytes;
            busOut.memSext <= busIn.memSext;
            busOut.pc <= busIn.pc;
            busOut.imm <= busIn.imm;
            busOut.rs1Val <= busIn.rs1Val;
            busOut.rs2Val <= busIn.rs2Val;
        end
    end

    aluOpKnown: assert property (@(posedge clk) disable iff (!rstN)
        busIn.valid |-> !$isunknown(busIn.aluOp) && busIn.aluOp <= rvPkg::PASSB)
        else $error("decoder handed over a bad aluOp");

endmodule

// ==== src/decodeBus.sv ====
`timescale 1ns/1ns

interface decodeBus ();
    logic valid;
    rvPkg::aluOpE aluOp;
    rvPkg::xlenT opA;
    rvPkg::xlenT opB;
    rvPkg::wbSelE wbSel;
    rvPkg::flowE flow;
    rvPkg::brCondE brCond;
    rvPkg::regIdxT rdAddr;
    logic writeRd;
    rvPkg::byteMaskT memMask;
    logic memRead;
    logic [3:0] memBytes;
    logic memSext;
    rvPkg::xlenT pc;
    rvPkg::xlenT imm;
    rvPkg::xlenT rs1Val;
    rvPkg::xlenT rs2Val;
    logic illegal;
    logic halt;

    modport producer (
        output valid, aluOp, opA, opB,
        output wbSel, flow, brCond, rdAddr, writeRd,
        output memMask, memRead, memBytes, memSext,
        output pc, imm, rs1Val, rs2Val, illegal, halt
    );

    modport consumer (
        input valid, aluOp, opA, opB,
        input wbSel, flow, brCond, rdAddr, writeRd,
        input memMask, memRead, memBytes, memSext,
        input pc, imm, rs1Val, rs2Val, illegal, halt
    );
endinterface

// ==== src/execBus.sv ====
`timescale 1ns/1ns

interface execBus ();
    logic valid;
    rvPkg::xlenT aluResult;
    rvPkg::wbSelE wbSel;
    rvPkg::flowE flow;
    rvPkg::brCondE brCond;
    rvPkg::regIdxT rdAddr;
    logic writeRd;
    rvPkg::byteMaskT memMask;
    logic memRead;
    logic [3:0] memBytes;
    logic memSext;
    rvPkg::xlenT pc;
    rvPkg::xlenT imm;
    rvPkg::xlenT rs1Val;
    rvPkg::xlenT rs2Val;
    logic illegal;
    logic halt;

    modport producer (
        output valid, aluResult, wbSel, flow, brCond, rdAddr, writeRd,
        output memMask, memRead, memBytes, memSext,
        output pc, imm, rs1Val, rs2Val, illegal, halt
    );

    modport consumer (
        input valid, aluResult, wbSel, flow, brCond, rdAddr, writeRd,
        input memMask, memRead, memBytes, memSext,
        input pc, imm, rs1Val, rs2Val, illegal, halt
    );
endinterface

// ==== src/instDecoder.sv ====
`timescale 1ns/1ns
`include "rvDefs_defs.svh"

module instDecoder (
    input  logic clk,
    input  logic rstN,
    input  logic req,
    output logic ack,
    input  rvPkg::instT inst,
    input  rvPkg::xlenT pc,
    input  rvPkg::xlenT rs1Val,
    input  rvPkg::xlenT rs2Val,
    decodeBus.producer busOut,
    input  logic resultDone
);
    rvPkg::hsStateE state;
    logic capture;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic altOk;
    rvPkg::xlenT immI, immS, immB, immU, immJ;
    rvPkg::xlenT imm, opA, opB;
    rvPkg::aluOpE aluOp;
    rvPkg::wbSelE wbSel;
    rvPkg::flowE flow;
    rvPkg::brCondE brCond;
    rvPkg::byteMaskT memMask;
    logic [3:0] memBytes;
    logic writeRd, memRead, memSext, illegal, halt;
    logic selPc, selImm, wordOp;

    function automatic rvPkg::aluOpE f3ToOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rvPkg::SUB : rvPkg::ADD;
            3'b001:  return rvPkg::SLL;
            3'b010:  return rvPkg::SLT;
            3'b011:  return rvPkg::SLTU;
            3'b100:  return rvPkg::XOR;
            3'b101:  return alt ? rvPkg::SRA : rvPkg::SRL;
            3'b110:  return rvPkg::OR;
            default: return rvPkg::AND;
        endcase
    endfunction

    assign capture = (state == rvPkg::IDLE) && req;
    assign ack = (state == rvPkg::ACK);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= rvPkg::IDLE;
        end else begin
            case (state)
                rvPkg::IDLE: if (req) state <= rvPkg::BUSY;
                rvPkg::BUSY: if (resultDone) state <= rvPkg::ACK;
                rvPkg::ACK:  if (!req) state <= rvPkg::IDLE; // hold while req high
                default:     state <= rvPkg::IDLE;
            endcase
        end
    end

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign altOk = (funct3 == 3'b000) || (funct3 == 3'b101); // sub / sra slots

    assign immI = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
    assign immS = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{(`RV_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{(`RV_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        aluOp = rvPkg::ADD;
        wbSel = rvPkg::ALU;
        flow = rvPkg::SEQ;
        brCond = rvPkg::EQ;
        imm = immI;
        selPc = 1'b0;
        selImm = 1'b1;
        wordOp = 1'b0;
        writeRd = 1'b1;
        memMask = '0;
        memRead = 1'b0;
        memBytes = 4'h0;
        memSext = 1'b0;
        illegal = 1'b0;
        halt = 1'b0;
        case (opcode)
            `RV_OP_OP: begin
                selImm = 1'b0;
                aluOp = f3ToOp(funct3, funct7[5]);
                illegal = !(funct7 == 7'h00 || (funct7 == 7'h20 && altOk)); // mul lands here
            end
            `RV_OP_IMM: begin
                aluOp = f3ToOp(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001)
                    illegal = (inst[31:26] != 6'h00);
                else if (funct3 == 3'b101)
                    illegal = inst[31] || (inst[29:26] != 4'h0);
            end
            `RV_OP_32: begin
                selImm = 1'b0;
                wordOp = 1'b1;
                wbSel = rvPkg::WORD;
                aluOp = f3ToOp(funct3, funct7[5]);
                illegal = !((funct7 == 7'h00 && (altOk || funct3 == 3'b001))
                    || (funct7 == 7'h20 && altOk));
            end
            `RV_OP_IMM32: begin
                wordOp = 1'b1;
                wbSel = rvPkg::WORD;
                aluOp = f3ToOp(funct3, funct3 == 3'b101 && funct7[5]);
                case (funct3)
                    3'b000:  illegal = 1'b0;
                    3'b001:  illegal = (funct7 != 7'h00);
                    3'b101:  illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
                    default: illegal = 1'b1;
                endcase
            end
            `RV_OP_LUI: begin
                imm = immU;
                aluOp = rvPkg::PASSB;
            end
            `RV_OP_AUIPC: begin
                imm = immU;
                selPc = 1'b1;
            end
            `RV_OP_JAL: begin
                imm = immJ;
                selPc = 1'b1;
                wbSel = rvPkg::LINK;
                flow = rvPkg::JAL;
            end
            `RV_OP_JALR: begin
                wbSel = rvPkg::LINK;
                flow = rvPkg::JALR;
                illegal = (funct3 != 3'b000);
            end
            `RV_OP_BRANCH: begin
                imm = immB;
                writeRd = 1'b0;
                flow = rvPkg::BRANCH;
                case (funct3)
                    3'b000:  brCond = rvPkg::EQ;
                    3'b001:  brCond = rvPkg::NE;
                    3'b100:  brCond = rvPkg::LT;
                    3'b101:  brCond = rvPkg::GE;
                    3'b110:  brCond = rvPkg::LTU;
                    3'b111:  brCond = rvPkg::GEU;
                    default: illegal = 1'b1;
                endcase
            end
            `RV_OP_LOAD: begin
                memRead = 1'b1;
                memBytes = 4'h1 << funct3[1:0];
                memSext = !funct3[2];
                illegal = (funct3 == 3'b111);
            end
            `RV_OP_STORE: begin
                imm = immS;
                writeRd = 1'b0;
                memBytes = 4'h1 << funct3[1:0];
                memMask = rvPkg::byteMaskT'((9'h1 << memBytes) - 9'h1); // 1, 3, 15, 255
                illegal = funct3[2];
            end
            `RV_OP_SYSTEM: begin
                writeRd = 1'b0;
                halt = (inst == 32'h0010_0073); // ebreak only
                illegal = !halt;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            writeRd = 1'b0;
            memRead = 1'b0;
            memMask = '0;
            flow = rvPkg::SEQ;
        end
    end

    always_comb begin
        opA = selPc ? pc : rs1Val;
        opB = selImm ? imm : rs2Val;
        if (wordOp && (aluOp == rvPkg::SLL || aluOp == rvPkg::SRL || aluOp == rvPkg::SRA))
            opB = rvPkg::xlenT'(opB[4:0]);
        if (wordOp && aluOp == rvPkg::SRL)
            opA = {32'b0, rs1Val[31:0]};
        else if (wordOp && aluOp == rvPkg::SRA)
            opA = {{32{rs1Val[31]}}, rs1Val[31:0]};
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busOut.valid <= 1'b0;
            busOut.writeRd <= 1'b0;
            busOut.memRead <= 1'b0;
            busOut.memMask <= '0;
            busOut.illegal <= 1'b0;
            busOut.halt <= 1'b0;
        end else begin
            busOut.valid <= capture; // one cycle pulse
            if (capture) begin
                busOut.writeRd <= writeRd;
                busOut.memRead <= memRead;
                busOut.memMask <= memMask;
                busOut.illegal <= illegal;
                busOut.halt <= halt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            busOut.aluOp <= aluOp;
            busOut.opA <= opA;
            busOut.opB <= opB;
            busOut.wbSel <= wbSel;
            busOut.flow <= flow;
            busOut.brCond <= brCond;
            busOut.rdAddr <= inst[11:7];
            busOut.memBytes <= memBytes;
            busOut.memSext <= memSext;
            busOut.pc <= pc;
            busOut.imm <= imm;
            busOut.rs1Val <= rs1Val;
            busOut.rs2Val <= rs2Val;
        end
    end

    // ack only out of BUSY, four edges after the capture edge
    ackFromBusy: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(state == rvPkg::BUSY) && $past(capture, 4))
        else $error("ack rose outside BUSY or off the four edge latency");

endmodule

// ==== src/resultUnit.sv ====
`timescale 1ns/1ns

module resultUnit (
    input  logic clk,
    input  logic rstN,
    execBus.consumer busIn,
    output logic done,
    output rvPkg::xlenT rdData,
    output rvPkg::xlenT nextPc,
    output rvPkg::xlenT memAddr,
    output rvPkg::xlenT storeData,
    output rvPkg::regIdxT rdAddr,
    output logic writeRd,
    output logic memRead,
    output logic memSext,
    output logic illegal,
    output logic halt,
    output rvPkg::byteMaskT memMask,
    output logic [3:0] memBytes
);
    logic taken;
    rvPkg::xlenT seqPc, target, jumpPc, wbValue;

    always_comb begin
        case (busIn.brCond)
            rvPkg::EQ:  taken = (busIn.rs1Val == busIn.rs2Val);
            rvPkg::NE:  taken = (busIn.rs1Val != busIn.rs2Val);
            rvPkg::LT:  taken = ($signed(busIn.rs1Val) < $signed(busIn.rs2Val));
            rvPkg::GE:  taken = ($signed(busIn.rs1Val) >= $signed(busIn.rs2Val));
            rvPkg::LTU: taken = (busIn.rs1Val < busIn.rs2Val);
            rvPkg::GEU: taken = (busIn.rs1Val >= busIn.rs2Val);
            default:    taken = 1'b0;
        endcase
    end

    assign seqPc = busIn.pc + rvPkg::xlenT'(4);
    assign target = busIn.pc + busIn.imm;

    always_comb begin
        case (busIn.flow)
            rvPkg::BRANCH: jumpPc = taken ? target : seqPc;
            rvPkg::JAL:    jumpPc = target;
            rvPkg::JALR:   jumpPc = {busIn.aluResult[63:1], 1'b0}; // lsb cleared
            default:       jumpPc = seqPc;
        endcase
        case (busIn.wbSel)
            rvPkg::LINK: wbValue = seqPc;
            rvPkg::WORD: wbValue = {{32{busIn.aluResult[31]}}, busIn.aluResult[31:0]};
            default:     wbValue = busIn.aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            done <= 1'b0;
            writeRd <= 1'b0;
            memRead <= 1'b0;
            memMask <= '0;
            memBytes <= 4'h0;
            memSext <= 1'b0;
            illegal <= 1'b0;
            halt <= 1'b0;
        end else begin
            done <= busIn.valid; // outputs valid from here on
            if (busIn.valid) begin
                writeRd <= busIn.writeRd;
                memRead <= busIn.memRead;
                memMask <= busIn.memMask;
                memBytes <= busIn.memBytes;
                memSext <= busIn.memSext;
                illegal <= busIn.illegal;
                halt <= busIn.halt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busIn.valid) begin
            rdData <= wbValue;
            nextPc <= jumpPc;
            memAddr <= busIn.aluResult; // rs1 + imm
            storeData <= busIn.rs2Val;
            rdAddr <= busIn.rdAddr;
        end
    end

    noLoadStoreMix: assert property (@(posedge clk) disable iff (!rstN)
        !(memRead && memMask != '0))
        else $error("load and store requested together");

endmodule

// ==== src/rvDefs_defs.svh ====
`ifndef RVDEFS_DEFS_SVH
`define RVDEFS_DEFS_SVH

`define RV_XLEN 64
`define RV_INST_W 32

// base opcodes, inst[6:0]
`define RV_OP_OP     7'b0110011
`define RV_OP_IMM    7'b0010011
`define RV_OP_32     7'b0111011
`define RV_OP_IMM32  7'b0011011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_SYSTEM 7'b1110011

`endif

// ==== src/rvExecTop.sv ====
`timescale 1ns/1ns

module rvExecTop (
    input  logic clk,
    input  logic rstN,
    input  logic req,
    input  rvPkg::instT inst,
    input  rvPkg::xlenT pc,
    input  rvPkg::xlenT rs1Val,
    input  rvPkg::xlenT rs2Val,
    output logic ack,
    output rvPkg::xlenT rdData,
    output rvPkg::regIdxT rdAddr,
    output logic writeRd,
    output rvPkg::xlenT nextPc,
    output rvPkg::xlenT memAddr,
    output rvPkg::xlenT storeData,
    output rvPkg::byteMaskT memMask,
    output logic memRead,
    output logic [3:0] memBytes,
    output logic memSext,
    output logic illegal,
    output logic halt
);
    decodeBus dBus ();
    execBus eBus ();
    logic resultDone;

    instDecoder uDecoder (
        .clk(clk),
        .rstN(rstN),
        .req(req),
        .ack(ack),
        .inst(inst),
        .pc(pc),
        .rs1Val(rs1Val),
        .rs2Val(rs2Val),
        .busOut(dBus),
        .resultDone(resultDone)
    );

    aluExecute uAlu (
        .clk(clk),
        .rstN(rstN),
        .busIn(dBus),
        .busOut(eBus)
    );

    resultUnit uResult (
        .clk(clk),
        .rstN(rstN),
        .busIn(eBus),
        .done(resultDone),
        .rdData(rdData),
        .nextPc(nextPc),
        .memAddr(memAddr),
        .storeData(storeData),
        .rdAddr(rdAddr),
        .writeRd(writeRd),
        .memRead(memRead),
        .memSext(memSext),
        .illegal(illegal),
        .halt(halt),
        .memMask(memMask),
        .memBytes(memBytes)
    );

endmodule

// ==== src/rvPkg.sv ====
`include "rvDefs_defs.svh"

package rvPkg;

    typedef logic [`RV_XLEN-1:0] xlenT;
    typedef logic [`RV_INST_W-1:0] instT;
    typedef logic [4:0] regIdxT;
    typedef logic [7:0] byteMaskT;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        PASSB // lui
    } aluOpE;

    typedef enum logic [1:0] {
        ALU,
        LINK, // pc + 4
        WORD  // sext of low word
    } wbSelE;

    typedef enum logic [1:0] {SEQ, BRANCH, JAL, JALR} flowE;

    typedef enum logic [2:0] {EQ, NE, LT, GE, LTU, GEU} brCondE;

    typedef enum logic [1:0] {IDLE, BUSY, ACK} hsStateE;

endpackage
